//--- beta_llr/beta_recursion.sv
`include "siso_defs.svh"

module beta_recursion
	import siso_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  replay_t    replay_i,
	output beta_step_t beta_o
);

	// known end state, state 0 at zero and the rest pushed down
	localparam state_vec_t BETA_INIT = {
		{(`SISO_STATES-1){metric_t'(`SISO_BETA_INIT)}},
		metric_t'(0)
	};

	metric_t    g1;
	metric_t    g2;
	state_vec_t beta_cur;
	state_vec_t beta_in;
	state_vec_t beta_raw;
	state_vec_t beta_norm;

	step_t      step_q;
	state_vec_t beta_q;
	logic       valid_q;

	assign g1 = replay_i.step.gamma1;
	assign g2 = replay_i.step.gamma2;

	// a new block restarts from the end state
	assign beta_in = replay_i.first ? BETA_INIT : beta_cur;

	//////////////////////////////////////////////////////////////////////
	// butterfly
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		beta_raw[0] = metric_max(beta_in[0] + g1, beta_in[4] - g1);
		beta_raw[1] = metric_max(beta_in[4] + g1, beta_in[0] - g1);
		beta_raw[2] = metric_max(beta_in[5] + g2, beta_in[1] - g2);
		beta_raw[3] = metric_max(beta_in[1] + g2, beta_in[5] - g2);
		beta_raw[4] = metric_max(beta_in[2] + g2, beta_in[6] - g2);
		beta_raw[5] = metric_max(beta_in[6] + g2, beta_in[2] - g2);
		beta_raw[6] = metric_max(beta_in[7] + g1, beta_in[3] - g1);
		beta_raw[7] = metric_max(beta_in[3] + g1, beta_in[7] - g1);
	end

	// normalize to the new state 0 so the metrics stay bounded
	always_comb begin
		for (int s = 0; s < `SISO_STATES; s++)
			beta_norm[s] = beta_raw[s] - beta_raw[0];
	end

	always_ff @(posedge clk) begin
		if (replay_i.valid)
			beta_cur <= beta_norm;
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	// the step leaves with the beta it entered with
	always_ff @(posedge clk) begin
		step_q <= replay_i.step;
		beta_q <= beta_in;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= replay_i.valid;
	end

	assign beta_o = '{step: step_q, beta_next: beta_q, valid: valid_q};

endmodule

//--- beta_llr/llr_extrinsic.sv
`include "siso_defs.svh"

module llr_extrinsic
	import siso_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  beta_step_t beta_i,
	output metric_t    ext_o,
	output logic       ext_valid_o
);

	localparam int HALF = `SISO_STATES / 2;

	// beta index reached from each state on a one and on a zero
	localparam int ONE_POS  [`SISO_STATES] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int ZERO_POS [`SISO_STATES] = '{0, 4, 5, 1, 2, 6, 7, 3};

	// states whose branches carry gamma1, the rest carry gamma2
	localparam logic [`SISO_STATES-1:0] USE_G1 = 8'b1100_0011;

	// stage 1
	state_vec_t           gam;
	state_vec_t           one_sum;
	state_vec_t           zero_sum;
	state_vec_t           one_q;
	state_vec_t           zero_q;
	metric_t              sys_q1;
	metric_t              apr_q1;
	logic                 valid_q1;

	// stage 2
	metric_t [HALF-1:0]   one_m;
	metric_t [HALF-1:0]   zero_m;
	metric_t [HALF-1:0]   one_mq;
	metric_t [HALF-1:0]   zero_mq;
	metric_t              sys_q2;
	metric_t              apr_q2;
	logic                 valid_q2;

	// stage 3
	metric_t              one_max;
	metric_t              zero_max;
	metric_t              llr;

	//////////////////////////////////////////////////////////////////////
	// stage 1, path sums
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int s = 0; s < `SISO_STATES; s++) begin
			gam[s] = USE_G1[s] ? beta_i.step.gamma1 : beta_i.step.gamma2;
			one_sum[s] = beta_i.step.alpha[s] - gam[s] + beta_i.beta_next[ONE_POS[s]];
			zero_sum[s] = beta_i.step.alpha[s] + gam[s] + beta_i.beta_next[ZERO_POS[s]];
		end
	end

	always_ff @(posedge clk) begin
		one_q <= one_sum;
		zero_q <= zero_sum;
		sys_q1 <= beta_i.step.sys;
		apr_q1 <= beta_i.step.apriori;
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2, first max level
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < HALF; i++) begin
			one_m[i] = metric_max(one_q[2*i], one_q[2*i+1]);
			zero_m[i] = metric_max(zero_q[2*i], zero_q[2*i+1]);
		end
	end

	always_ff @(posedge clk) begin
		one_mq <= one_m;
		zero_mq <= zero_m;
		sys_q2 <= sys_q1;
		apr_q2 <= apr_q1;
	end

	//////////////////////////////////////////////////////////////////////
	// stage 3, remaining levels and extrinsic
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		one_max = metric_max(metric_max(one_mq[0], one_mq[1]),
			metric_max(one_mq[2], one_mq[3]));
		zero_max = metric_max(metric_max(zero_mq[0], zero_mq[1]),
			metric_max(zero_mq[2], zero_mq[3]));
		// strip the channel and a-priori parts, wraps at metric width
		llr = one_max - zero_max - sys_q2 - apr_q2;
	end

	always_ff @(posedge clk) begin
		ext_o <= metric_t'(llr * `SISO_EXT_SCALE);
	end

	// valids run alongside the three stages
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
			ext_valid_o <= 1'b0;
		end else begin
			valid_q1 <= beta_i.valid;
			valid_q2 <= valid_q1;
			ext_valid_o <= valid_q2;
		end
	end

endmodule

//--- beta_llr/trellis_store.sv
`include "siso_defs.svh"

module trellis_store
	import siso_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    blk_start_i,
	input  blklen_t blklen_i,
	input  step_t   step_i,
	input  logic    step_valid_i,
	output replay_t replay_o,
	output logic    ready_o
);

	localparam int ADDR_W = $clog2(`SISO_MAX_BLK);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_REPLAY
	} store_state_t;

	store_state_t      state;
	blklen_t           cnt;
	blklen_t           last_idx;
	logic              last_load;
	logic [ADDR_W-1:0] addr;

	step_t             mem [`SISO_MAX_BLK];
	step_t             rd_step;
	logic              rd_first;
	logic              rd_valid;

	// one counter serves both directions
	assign addr = cnt[ADDR_W-1:0];
	assign last_load = (state == ST_LOAD) && step_valid_i && (cnt == last_idx);

	//////////////////////////////////////////////////////////////////////
	// load and replay controller
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cnt <= '0;
			last_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (blk_start_i) begin
						last_idx <= blklen_i - 1'b1;
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					// counter stays on the last address for the first read
					if (last_load)
						state <= ST_REPLAY;
					else if (step_valid_i)
						cnt <= cnt + 1'b1;
				end
				ST_REPLAY: begin
					if (cnt == '0)
						state <= ST_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// step memory
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == ST_LOAD && step_valid_i)
			mem[addr] <= step_i;
	end

	// registered read, one step per cycle
	always_ff @(posedge clk) begin
		if (state == ST_REPLAY)
			rd_step <= mem[addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
			rd_first <= 1'b0;
		end else begin
			rd_valid <= (state == ST_REPLAY);
			rd_first <= (state == ST_REPLAY) && (cnt == last_idx);
		end
	end

	assign replay_o = '{step: rd_step, first: rd_first, valid: rd_valid};
	assign ready_o = (state == ST_IDLE);

endmodule

//--- build.f
+incdir+common
common/siso_pkg.sv
beta_llr/trellis_store.sv
beta_llr/beta_recursion.sv
beta_llr/llr_extrinsic.sv
verilog/beta_llr_top.sv
sim/beta_llr_sva.sv
sim/beta_llr_tb.sv

//--- common/siso_defs.svh
`ifndef SISO_DEFS_SVH
`define SISO_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// metric arithmetic
//////////////////////////////////////////////////////////////////////

// every metric word, gammas, alphas, betas and extrinsic alike
`define SISO_METRIC_W 16

// eight-state constituent trellis
`define SISO_STATES 8

//////////////////////////////////////////////////////////////////////
// block store
//////////////////////////////////////////////////////////////////////

// deepest block the step memory holds
`define SISO_MAX_BLK 64

// block length and step counter width, must reach SISO_MAX_BLK
`define SISO_BLK_W 7

//////////////////////////////////////////////////////////////////////
// recursion and output
//////////////////////////////////////////////////////////////////////

// start metric of states 1 to 7, state 0 starts at zero
`define SISO_BETA_INIT (-128)

// extrinsic multiplier
`define SISO_EXT_SCALE 2

`endif

//--- common/siso_pkg.sv
`include "siso_defs.svh"

package siso_pkg;

	// one signed metric word
	typedef logic signed [`SISO_METRIC_W-1:0] metric_t;

	// one metric per trellis state, used for alpha and beta
	typedef metric_t [`SISO_STATES-1:0] state_vec_t;

	typedef logic [`SISO_BLK_W-1:0] blklen_t;

	// one trellis step as it arrives from the forward half
	typedef struct packed {
		metric_t    gamma1;
		metric_t    gamma2;
		metric_t    sys;
		metric_t    apriori;
		state_vec_t alpha;
	} step_t;

	// step leaving the store in reverse order
	// first marks the last-loaded step of a block
	typedef struct packed {
		step_t step;
		logic  first;
		logic  valid;
	} replay_t;

	// replayed step together with the normalized beta of its successor
	typedef struct packed {
		step_t      step;
		state_vec_t beta_next;
		logic       valid;
	} beta_step_t;

	// signed max, wraps are the caller's business
	function automatic metric_t metric_max(input metric_t a, input metric_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module beta_llr_tb -f build.f -o beta_llr_sim &&
	./obj_dir/beta_llr_sim 2>&1 | tee sim.log
grep -q "^Simulation completed successfully$" sim.log &&
	echo "run passed" ||
	{ echo "run failed"; exit 1; }

//--- sim/beta_llr_sva.sv
module beta_llr_sva
	import siso_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    blk_start_i,
	input logic    ready_o,
	input metric_t ext_o,
	input logic    ext_valid_o
);

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	reset_state: assert property (@(posedge clk) $fell(rst) |-> ready_o && !ext_valid_o)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("** Error ready_o/ext_valid_o after reset: got %h/%h expected 1/0",
				ready_o, ext_valid_o);
		end

	no_early_output: assert property (@(posedge clk) disable iff (rst)
		beta_llr_tb.loaded_blks == 0 |-> !ext_valid_o)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("ext_valid_o went high before any block was loaded");
		end

	// busy from the start strobe on
	start_takes_store: assert property (@(posedge clk) disable iff (rst)
		ready_o && blk_start_i |=> !ready_o)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("ready_o stayed high after an accepted start strobe");
		end

	ready_drop: assert property (@(posedge clk) disable iff (rst)
		$fell(ready_o) |-> $past(blk_start_i))
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("ready_o dropped without a start strobe");
		end

	// replay ends N cycles after the last load
	ready_return: assert property (@(posedge clk) disable iff (rst)
		$rose(ready_o) && beta_llr_tb.loaded_blks != 0 |->
		beta_llr_tb.cycle == beta_llr_tb.last_load_cycle[beta_llr_tb.loaded_blks - 1]
		+ beta_llr_tb.blk_len[beta_llr_tb.loaded_blks - 1] + 1)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("** Error ready_o: rose at cycle %h, expected cycle %h", beta_llr_tb.cycle,
				beta_llr_tb.last_load_cycle[beta_llr_tb.loaded_blks - 1]
				+ beta_llr_tb.blk_len[beta_llr_tb.loaded_blks - 1] + 1);
		end

	//////////////////////////////////////////////////////////////////////
	// extrinsic output
	//////////////////////////////////////////////////////////////////////

	no_extra_output: assert property (@(posedge clk) disable iff (rst)
		ext_valid_o |-> beta_llr_tb.out_idx < beta_llr_tb.exp_count)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("more extrinsic outputs than loaded steps");
		end

	ext_value: assert property (@(posedge clk) disable iff (rst)
		ext_valid_o |-> ext_o == beta_llr_tb.exp_ext[beta_llr_tb.out_idx])
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("** Error ext_o: got %h expected %h", ext_o,
				beta_llr_tb.exp_ext[beta_llr_tb.out_idx]);
		end

	// seen one edge after the rise, hence 6
	first_output_time: assert property (@(posedge clk) disable iff (rst)
		$rose(ext_valid_o) |->
		beta_llr_tb.cycle == beta_llr_tb.last_load_cycle[beta_llr_tb.out_blk] + 6)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("** Error ext_valid_o: rose at cycle %h, expected cycle %h",
				beta_llr_tb.cycle, beta_llr_tb.last_load_cycle[beta_llr_tb.out_blk] + 6);
		end

	burst_continues: assert property (@(posedge clk) disable iff (rst)
		ext_valid_o && beta_llr_tb.run_pos < beta_llr_tb.blk_len[beta_llr_tb.out_blk] - 1
		|=> ext_valid_o)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("ext_valid_o dropped before the block was complete");
		end

	burst_ends: assert property (@(posedge clk) disable iff (rst)
		ext_valid_o && beta_llr_tb.run_pos == beta_llr_tb.blk_len[beta_llr_tb.out_blk] - 1
		|=> !ext_valid_o)
		else begin
			beta_llr_tb.fail_count = beta_llr_tb.fail_count + 1;
			$error("ext_valid_o stayed high past the end of the block");
		end

endmodule

//--- sim/beta_llr_tb.sv
`include "siso_defs.svh"

module beta_llr_tb
	import siso_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_BLOCKS = 12;
	localparam int MAX_OUT = N_BLOCKS * `SISO_MAX_BLK;

	// beta position reached from each state on a one and on a zero
	localparam int ONE_AT [8] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int ZERO_AT [8] = '{0, 4, 5, 1, 2, 6, 7, 3};

	logic        clk;
	logic        rst;
	logic        blk_start;
	blklen_t     blklen;
	step_t       step;
	logic        step_valid;
	logic        ready;
	metric_t     ext;
	logic        ext_valid;

	// model results, also read by the bound assertions
	metric_t     exp_ext [MAX_OUT];
	int          exp_count = 0;
	int          blk_len [N_BLOCKS];
	int          last_load_cycle [N_BLOCKS];
	int          loaded_blks = 0;

	// output tracking
	int          cycle = 0;
	int          out_idx = 0;
	int          out_blk = 0;
	int          run_pos = 0;

	int          fail_count = 0;
	int          wd_limit = 0;
	logic [31:0] rng = 32'd29;
	step_t       blk_steps [`SISO_MAX_BLK];

	beta_llr_top dut (
		.clk          (clk),
		.rst          (rst),
		.blk_start_i  (blk_start),
		.blklen_i     (blklen),
		.step_i       (step),
		.step_valid_i (step_valid),
		.ready_o      (ready),
		.ext_o        (ext),
		.ext_valid_o  (ext_valid)
	);

	bind beta_llr_top beta_llr_sva u_sva (
		.clk         (clk),
		.rst         (rst),
		.blk_start_i (blk_start_i),
		.ready_o     (ready_o),
		.ext_o       (ext_o),
		.ext_valid_o (ext_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// which block and which beat the next output belongs to
	always @(posedge clk) begin
		if (!rst && ext_valid) begin
			out_idx <= out_idx + 1;
			if (run_pos == blk_len[out_blk] - 1) begin
				run_pos <= 0;
				out_blk <= out_blk + 1;
			end else begin
				run_pos <= run_pos + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// random numbers and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned rand_below(input int unsigned span);
		rng = xorshift(rng);
		return rng % span;
	endfunction

	// kept within +-200
	function automatic metric_t rand_metric();
		return metric_t'(int'(rand_below(401)) - 200);
	endfunction

	function automatic metric_t larger(input metric_t a, input metric_t b);
		if (a > b)
			return a;
		return b;
	endfunction

	task automatic predict_block(input int n);
		state_vec_t beta;
		state_vec_t nb;
		metric_t    g1;
		metric_t    g2;
		metric_t    g;
		metric_t    t;
		metric_t    one_best;
		metric_t    zero_best;
		metric_t    diff;
		beta[0] = '0;
		for (int s = 1; s < 8; s++)
			beta[s] = metric_t'(`SISO_BETA_INIT);
		for (int k = n - 1; k >= 0; k--) begin
			g1 = blk_steps[k].gamma1;
			g2 = blk_steps[k].gamma2;
			one_best = '0;
			zero_best = '0;
			for (int s = 0; s < 8; s++) begin
				g = (s == 0 || s == 1 || s == 6 || s == 7) ? g1 : g2;
				t = blk_steps[k].alpha[s] - g + beta[ONE_AT[s]];
				one_best = (s == 0) ? t : larger(one_best, t);
				t = blk_steps[k].alpha[s] + g + beta[ZERO_AT[s]];
				zero_best = (s == 0) ? t : larger(zero_best, t);
			end
			diff = one_best - zero_best - blk_steps[k].sys - blk_steps[k].apriori;
			exp_ext[exp_count] = diff + diff;
			exp_count++;
			nb[0] = larger(beta[0] + g1, beta[4] - g1);
			nb[1] = larger(beta[4] + g1, beta[0] - g1);
			nb[2] = larger(beta[5] + g2, beta[1] - g2);
			nb[3] = larger(beta[1] + g2, beta[5] - g2);
			nb[4] = larger(beta[2] + g2, beta[6] - g2);
			nb[5] = larger(beta[6] + g2, beta[2] - g2);
			nb[6] = larger(beta[7] + g1, beta[3] - g1);
			nb[7] = larger(beta[3] + g1, beta[7] - g1);
			for (int s = 0; s < 8; s++)
				beta[s] = nb[s] - nb[0];
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic run_block(input int b, input bit gaps);
		int n;
		int unsigned gap;
		n = blk_len[b];
		for (int k = 0; k < n; k++) begin
			blk_steps[k].gamma1 = rand_metric();
			blk_steps[k].gamma2 = rand_metric();
			blk_steps[k].sys = rand_metric();
			blk_steps[k].apriori = rand_metric();
			for (int s = 0; s < 8; s++)
				blk_steps[k].alpha[s] = rand_metric();
		end
		predict_block(n);
		while (ready !== 1'b1) begin
			@(posedge clk);
			#10;
		end
		blk_start = 1'b1;
		blklen = blklen_t'(n);
		@(posedge clk);
		#10;
		blk_start = 1'b0;
		for (int k = 0; k < n; k++) begin
			if (gaps && rand_below(4) == 0) begin
				gap = rand_below(3) + 1;
				step_valid = 1'b0;
				// stray start inside the load window
				blk_start = 1'b1;
				blklen = blklen_t'(rand_below(64) + 1);
				repeat (gap) begin
					@(posedge clk);
					#10;
				end
				blk_start = 1'b0;
			end
			step = blk_steps[k];
			step_valid = 1'b1;
			if (k == n - 1) begin
				last_load_cycle[b] = cycle;
				loaded_blks++;
			end
			@(posedge clk);
			#10;
		end
		step_valid = 1'b0;
		// start strobe while the block replays
		blk_start = 1'b1;
		blklen = blklen_t'(rand_below(64) + 1);
		@(posedge clk);
		#10;
		blk_start = 1'b0;
	endtask

	initial begin
		int total;
		rst = 1'b1;
		blk_start = 1'b0;
		blklen = '0;
		step = '0;
		step_valid = 1'b0;
		blk_len[0] = 1;
		blk_len[1] = `SISO_MAX_BLK;
		blk_len[2] = 1;
		blk_len[3] = `SISO_MAX_BLK;
		for (int b = 4; b < N_BLOCKS; b++)
			blk_len[b] = int'(rand_below(`SISO_MAX_BLK)) + 1;
		total = 600;
		for (int b = 0; b < N_BLOCKS; b++)
			total += blk_len[b] + 20;
		wd_limit = total;
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b0;
		// a few idle cycles before the first block
		repeat (5) @(posedge clk);
		#10;
		for (int b = 0; b < N_BLOCKS; b++)
			run_block(b, b % 2 == 1);
		while (out_idx != exp_count || ready !== 1'b1) begin
			@(posedge clk);
			#10;
		end
		repeat (4) @(posedge clk);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "%0d assertion failures", fail_count);
		end
	end

	// stop at the first failed assertion
	initial begin
		wait (fail_count != 0);
		$display("Simulation failed");
		$fatal(1, "stopping at the first failed assertion");
	end

	initial begin
		wait (wd_limit != 0);
		repeat (wd_limit) @(posedge clk);
		$display("Simulation failed");
		$fatal(1, "watchdog expired after %0d cycles", wd_limit);
	end

endmodule

//--- verilog/beta_llr_top.sv
module beta_llr_top
	import siso_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	// block control
	input  logic    blk_start_i,
	input  blklen_t blklen_i,

	// trellis steps in load order
	input  step_t   step_i,
	input  logic    step_valid_i,

	output logic    ready_o,

	// extrinsic in reverse step order
	output metric_t ext_o,
	output logic    ext_valid_o
);

	replay_t    replay;
	beta_step_t beta_step;

	//////////////////////////////////////////////////////////////////////
	// block store, replays last step first
	//////////////////////////////////////////////////////////////////////

	trellis_store u_store (
		.clk          (clk),
		.rst          (rst),
		.blk_start_i  (blk_start_i),
		.blklen_i     (blklen_i),
		.step_i       (step_i),
		.step_valid_i (step_valid_i),
		.replay_o     (replay),
		.ready_o      (ready_o)
	);

	//////////////////////////////////////////////////////////////////////
	// backward state metrics
	//////////////////////////////////////////////////////////////////////

	beta_recursion u_beta (
		.clk      (clk),
		.rst      (rst),
		.replay_i (replay),
		.beta_o   (beta_step)
	);

	//////////////////////////////////////////////////////////////////////
	// path sums and extrinsic
	//////////////////////////////////////////////////////////////////////

	llr_extrinsic u_llr (
		.clk         (clk),
		.rst         (rst),
		.beta_i      (beta_step),
		.ext_o       (ext_o),
		.ext_valid_o (ext_valid_o)
	);

endmodule
